//--- Makefile
# Verilator flow for the RV32I core testbench

VERILATOR       ?= verilator
TOP             ?= tb_riscv_core
LOG             ?= sim.log
BUILD_DIR       ?= obj_dir
FILE_LIST       ?= compile.f
VERILATOR_FLAGS ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
verilog/core_pkg.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/riscv_core_top.sv
verification/core_properties.sv
verification/tb_riscv_core.sv

//--- verification/core_properties.sv
// ====================
// Handshake and x0 write assertions for the core top
// ====================
module core_properties (
    input logic              clk,
    input logic              reset,
    input logic              inst_valid,
    input logic              dec_valid,
    input logic              retire_valid,
    input core_pkg::retire_t retire
);

    // Fixed latency, checked in both directions
    a_latency: assert property (@(posedge clk) disable iff (reset)
        retire_valid == $past(inst_valid, 2))
        else $error("retire_valid is not inst_valid delayed by two cycles");

    // One instruction in flight at a time
    a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> !dec_valid && !retire_valid)
        else $error("inst_valid raised while an instruction is in flight");

    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> !(retire.we && retire.rd == '0))
        else $error("Retire record writes x0");

endmodule

bind riscv_core_top core_properties i_core_properties (
    .clk         (clk),
    .reset       (reset),
    .inst_valid  (inst_valid),
    .dec_valid   (dec_valid),  // Internal decode strobe
    .retire_valid(retire_valid),
    .retire      (retire)
);

//--- verification/tb_riscv_core.sv
// ====================
// Testbench for the RV32I core with program table, fetch loop and checks
// ====================
module tb_riscv_core;
    import core_pkg::*;

    localparam int    period   = 8;
    localparam word_t reset_pc = 32'h8000_0000;
    localparam int    op_imm   = 'h13;
    localparam int    op_lui   = 'h37;
    localparam int    op_auipc = 'h17;
    localparam int    op_jalr  = 'h67;

    typedef struct packed {
        word_t      inst;
        word_t      pc;
        word_t      next_pc;
        logic       we;
        logic [4:0] rd;
        word_t      wdata;
        logic       illegal;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    word_t       inst;
    word_t       fetch_pc;
    logic        retire_valid;
    retire_t     retire;
    entry_t      prog[$];
    logic [16:0] lfsr_state  = 17'd99859;
    int          cycle_count = 0;

    riscv_core_top #(
        .reset_pc(reset_pc)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .fetch_pc    (fetch_pc),
        .retire_valid(retire_valid),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // RV32I encoders, fields taken straight from the ISA layouts
    function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic word_t i_type(int imm, int rs1, int f3, int rd, int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t u_type(int imm, int rd, int opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic word_t j_type(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic word_t b_type(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    // Fibonacci LFSR, x^17 + x^14 + 1
    function automatic logic next_random_bit();
        logic fb;
        fb         = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], fb};
        return fb;
    endfunction

    task automatic add_entry(input word_t inst_word, input int pc_off, input int next_off,
                             input int we, input int rd, input word_t wdata, input int illegal);
        entry_t e;
        e.inst    = inst_word;
        e.pc      = reset_pc + word_t'(pc_off);  // Offsets from the boot vector
        e.next_pc = reset_pc + word_t'(next_off);
        e.we      = we != 0;
        e.rd      = rd[4:0];
        e.wdata   = wdata;
        e.illegal = illegal != 0;
        prog.push_back(e);
    endtask

    task automatic build_program();
        // Immediate and register ALU ops, x1 = 5 and x2 = -8 feed the rest
        add_entry(i_type(5, 0, 0, 1, op_imm),      'h00, 'h04, 1, 1, 32'h0000_0005, 0);
        add_entry(i_type(-8, 0, 0, 2, op_imm),     'h04, 'h08, 1, 2, 32'hffff_fff8, 0);
        add_entry(r_type('h20, 2, 1, 0, 3),        'h08, 'h0c, 1, 3, 32'h0000_000d, 0);
        add_entry(i_type(3, 1, 1, 4, op_imm),      'h0c, 'h10, 1, 4, 32'h0000_0028, 0);
        add_entry(i_type('h401, 2, 5, 5, op_imm),  'h10, 'h14, 1, 5, 32'hffff_fffc, 0);
        add_entry(i_type(4, 2, 5, 6, op_imm),      'h14, 'h18, 1, 6, 32'h0fff_ffff, 0);
        add_entry(r_type('h20, 1, 2, 5, 7),        'h18, 'h1c, 1, 7, 32'hffff_ffff, 0);
        add_entry(r_type(0, 1, 1, 1, 8),           'h1c, 'h20, 1, 8, 32'h0000_00a0, 0);
        add_entry(r_type(0, 1, 2, 5, 9),           'h20, 'h24, 1, 9, 32'h07ff_ffff, 0);
        add_entry(r_type(0, 1, 2, 2, 10),          'h24, 'h28, 1, 10, 32'h0000_0001, 0);
        add_entry(r_type(0, 1, 2, 3, 11),          'h28, 'h2c, 1, 11, 32'h0000_0000, 0);
        add_entry(i_type(-1, 1, 3, 12, op_imm),    'h2c, 'h30, 1, 12, 32'h0000_0001, 0);
        add_entry(r_type(0, 2, 1, 4, 13),          'h30, 'h34, 1, 13, 32'hffff_fffd, 0);
        add_entry(r_type(0, 4, 1, 6, 14),          'h34, 'h38, 1, 14, 32'h0000_002d, 0);
        add_entry(r_type(0, 4, 2, 7, 15),          'h38, 'h3c, 1, 15, 32'h0000_0028, 0);
        add_entry(u_type('h12345, 16, op_lui),     'h3c, 'h40, 1, 16, 32'h1234_5000, 0);
        add_entry(u_type(1, 17, op_auipc),         'h40, 'h44, 1, 17, 32'h8000_1040, 0);
        // Write to x0 is dropped, then x0 reads back as zero
        add_entry(i_type(7, 1, 0, 0, op_imm),      'h44, 'h48, 0, 0, 32'h0, 0);
        add_entry(r_type(0, 1, 0, 0, 18),          'h48, 'h4c, 1, 18, 32'h0000_0005, 0);
        // JAL, then JALR with an odd target
        add_entry(j_type(16, 19),                  'h4c, 'h5c, 1, 19, 32'h8000_0050, 0);
        add_entry(u_type(0, 21, op_auipc),         'h5c, 'h60, 1, 21, 32'h8000_005c, 0);
        add_entry(i_type(21, 21, 0, 20, op_jalr),  'h60, 'h70, 1, 20, 32'h8000_0064, 0);
        // Each branch taken then not taken
        add_entry(b_type(8, 1, 1, 0),              'h70, 'h78, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 2, 1, 0),              'h78, 'h7c, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 2, 1, 1),              'h7c, 'h84, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 1, 1, 1),              'h84, 'h88, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 1, 2, 4),              'h88, 'h90, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 2, 1, 4),              'h90, 'h94, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 2, 1, 5),              'h94, 'h9c, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 1, 2, 5),              'h9c, 'ha0, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 2, 1, 6),              'ha0, 'ha8, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 1, 2, 6),              'ha8, 'hac, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 1, 2, 7),              'hac, 'hb4, 0, 0, 32'h0, 0);
        add_entry(b_type(8, 2, 1, 7),              'hb4, 'hb8, 0, 0, 32'h0, 0);
        add_entry(b_type(-56, 0, 1, 1),            'hb8, 'h80, 0, 0, 32'h0, 0);  // Backward
        // Custom-0 opcode, then an add that wraps
        add_entry(32'h0000_000b,                   'h80, 'h84, 0, 0, 32'h0, 1);
        add_entry(r_type(0, 4, 13, 0, 22),         'h84, 'h88, 1, 22, 32'h0000_0025, 0);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Mismatch at time %0t", $time);
        end
    endtask

    task automatic run_entry(input entry_t e);
        logic [1:0] gap_bits;
        int         gap;
        gap_bits[1] = next_random_bit();
        gap_bits[0] = next_random_bit();
        gap = 1 + int'(gap_bits) % 3;
        repeat (gap) @(posedge clk);
        #1;
        check_value("fetch_pc", fetch_pc, e.pc);
        inst_valid = 1'b1;
        inst       = e.inst;
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        inst       = '0;
        check_value("retire_valid", word_t'(retire_valid), '0);  // Still in decode
        @(posedge clk);
        #1;
        if (retire_valid !== 1'b1) begin
            $display("No retire strobe two cycles after the fetch at pc 0x%h", e.pc);
            $display("Testbench failed");
            $fatal(1, "Missing retire strobe");
        end
        check_value("retire.pc", retire.pc, e.pc);
        check_value("retire.next_pc", retire.next_pc, e.next_pc);
        check_value("retire.we", word_t'(retire.we), word_t'(e.we));
        check_value("retire.illegal", word_t'(retire.illegal), word_t'(e.illegal));
        if (e.we) begin
            check_value("retire.rd", word_t'(retire.rd), word_t'(e.rd));
            check_value("retire.wdata", retire.wdata, e.wdata);
        end
    endtask

    // Worst case per entry is 3 idle cycles plus 2 for the instruction
    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count > 6 * prog.size() + 50) begin
                $display("Timeout after %0d cycles, the program did not complete", cycle_count);
                $display("Testbench failed");
                $fatal(1, "Timeout");
            end
        end
    end

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        build_program();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) begin  // Idle at the boot vector
            check_value("fetch_pc", fetch_pc, reset_pc);
            check_value("retire_valid", word_t'(retire_valid), '0);
            @(posedge clk);
            #1;
        end
        foreach (prog[i]) begin
            run_entry(prog[i]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- verilog/alu.sv
// ====================
// Integer ALU, ten operations
// ====================
module alu (
    input  core_pkg::alu_op_t op,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    output core_pkg::word_t   result
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Upper bits ignored per ISA

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = word_t'($signed(a) < $signed(b));
            alu_sltu: result = word_t'(a < b);
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);  // Sign fill
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- verilog/core_pkg.sv
// ====================
// Core widths, opcode and class encodings
// Decode stage and retire record structs
// ====================
package core_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    typedef logic [xlen-1:0]           word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // Register-register
        opc_op_imm = 7'b0010011,  // Register-immediate
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // Format class, JALR split out from I since it jumps
    typedef enum logic [2:0] {
        class_r,
        class_i,
        class_u,
        class_j,
        class_b,
        class_jalr,
        class_bad  // Unknown opcode
    } inst_class_t;

    typedef struct packed {
        word_t       pc;
        inst_class_t inst_class;
        alu_op_t     alu_op;
        logic [2:0]  funct3;
        logic        is_lui;  // Operand A is zero instead of pc
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        word_t       imm;
    } decoded_t;

    typedef struct packed {
        word_t     pc;
        word_t     next_pc;
        reg_addr_t rd;
        word_t     wdata;
        logic      we;       // Never set for x0
        logic      illegal;
    } retire_t;

endpackage

//--- verilog/exec_unit.sv
// ====================
// Execute stage with branch resolution and retire record
// ====================
module exec_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               dec_valid,
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    rs1_data,
    input  core_pkg::word_t    rs2_data,
    output core_pkg::word_t    alu_a,
    output core_pkg::word_t    alu_b,
    output core_pkg::alu_op_t  alu_op,
    input  core_pkg::word_t    alu_result,
    output logic               retire_valid,
    output core_pkg::retire_t  retire
);
    import core_pkg::*;

    word_t pc_plus4;
    logic  taken;
    word_t next_pc;
    word_t wdata;
    logic  writes;

    assign pc_plus4 = dec.pc + word_t'(4);
    assign alu_op   = dec.alu_op;

    always_comb begin
        alu_a = rs1_data;
        alu_b = dec.imm;
        case (dec.inst_class)
            class_j, class_b: alu_a = dec.pc;  // Jump and branch targets
            class_u:          alu_a = dec.is_lui ? '0 : dec.pc;
            class_r:          alu_b = rs2_data;
            default:          alu_b = dec.imm;  // I and JALR keep rs1 plus imm
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = rs1_data == rs2_data;                  // BEQ
            3'b001:  taken = rs1_data != rs2_data;                  // BNE
            3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);  // BLT
            3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data); // BGE
            3'b110:  taken = rs1_data < rs2_data;                   // BLTU
            3'b111:  taken = rs1_data >= rs2_data;                  // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.inst_class)
            class_j:    next_pc = alu_result;
            class_b:    next_pc = taken ? alu_result : pc_plus4;
            class_jalr: next_pc = {alu_result[xlen-1:1], 1'b0};
            default:    next_pc = pc_plus4;  // Unknown opcodes fall through too
        endcase
    end

    // Link address for jumps, ALU result otherwise
    always_comb begin
        wdata  = alu_result;
        writes = 1'b0;
        case (dec.inst_class)
            class_j, class_jalr: begin
                wdata  = pc_plus4;
                writes = 1'b1;
            end
            class_r, class_i, class_u: writes = 1'b1;
            default:                   writes = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            retire.pc      <= dec.pc;
            retire.next_pc <= next_pc;
            retire.rd      <= dec.rd;
            retire.wdata   <= wdata;
            retire.we      <= writes && dec.rd != '0;
            retire.illegal <= dec.inst_class == class_bad;
        end
    end

endmodule

//--- verilog/inst_decoder.sv
// ====================
// Instruction decoder and decode stage register
// ====================
module inst_decoder (
    input  logic               clk,
    input  logic               reset,
    input  logic               inst_valid,
    input  core_pkg::word_t    inst,
    input  core_pkg::word_t    fetch_pc,
    output logic               dec_valid,
    output core_pkg::decoded_t dec
);
    import core_pkg::*;

    opcode_t     opcode;
    logic [2:0]  funct3;
    inst_class_t inst_class;
    alu_op_t     alu_op;
    word_t       imm;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];

    always_comb begin
        case (opcode)
            opc_op:             inst_class = class_r;
            opc_op_imm:         inst_class = class_i;
            opc_lui, opc_auipc: inst_class = class_u;
            opc_jal:            inst_class = class_j;
            opc_jalr:           inst_class = class_jalr;
            opc_branch:         inst_class = class_b;
            default:            inst_class = class_bad;
        endcase
    end

    // Sign-extended immediates per format
    always_comb begin
        case (inst_class)
            class_i, class_jalr: imm = {{20{inst[31]}}, inst[31:20]};
            class_u:             imm = {inst[31:12], 12'b0};
            class_j: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            class_b: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            default:             imm = '0;  // R and unknown
        endcase
    end

    // U, J, B and JALR all need an add
    always_comb begin
        alu_op = alu_add;
        if (inst_class == class_r || inst_class == class_i) begin
            case (funct3)
                3'b000:  alu_op = (inst_class == class_r && inst[30]) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = inst[30] ? alu_sra : alu_srl;  // SRAI too
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec.pc         <= fetch_pc;
            dec.inst_class <= inst_class;
            dec.alu_op     <= alu_op;
            dec.funct3     <= funct3;
            dec.is_lui     <= opcode == opc_lui;
            dec.rd         <= inst[11:7];
            dec.rs1        <= inst[19:15];
            dec.rs2        <= inst[24:20];
            dec.imm        <= imm;
        end
    end

endmodule

//--- verilog/pc_unit.sv
// ====================
// Program counter register
// ====================
module pc_unit #(
    parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            retire_valid,
    input  core_pkg::word_t next_pc,
    output core_pkg::word_t fetch_pc
);

    // Holds the pc of the instruction being fetched or in flight.
    // It only moves when the current instruction retires, so the
    // fetcher sees the redirect in the cycle after retire_valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_pc <= reset_pc;  // Boot vector
        end else if (retire_valid) begin
            fetch_pc <= next_pc;   // Sequential, jump or branch target
        end
    end

endmodule

//--- verilog/reg_file.sv
// ====================
// 32 x 32 integer register file
// ====================
module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t     rs1_data,
    output core_pkg::word_t     rs2_data,
    input  logic                we,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::word_t     wdata
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 is hardwired
            regs[rd] <= wdata;
        end
    end

    // Combinational read ports
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- verilog/riscv_core_top.sv
// ====================
// Single-issue RV32I core top level
// ====================
module riscv_core_top #(
    parameter core_pkg::word_t reset_pc = 32'h8000_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              inst_valid,
    input  core_pkg::word_t   inst,
    output core_pkg::word_t   fetch_pc,
    output logic              retire_valid,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    logic     dec_valid;
    decoded_t dec;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_a;
    word_t    alu_b;
    alu_op_t  alu_op;
    word_t    alu_result;

    pc_unit #(
        .reset_pc(reset_pc)
    ) i_pc_unit (
        .clk         (clk),
        .reset       (reset),
        .retire_valid(retire_valid),
        .next_pc     (retire.next_pc),
        .fetch_pc    (fetch_pc)
    );

    // Decode stage, one cycle after the fetch strobe
    inst_decoder i_inst_decoder (
        .clk       (clk),
        .reset     (reset),
        .inst_valid(inst_valid),
        .inst      (inst),
        .fetch_pc  (fetch_pc),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we      (retire_valid & retire.we),  // Write on the retire strobe only
        .rd      (retire.rd),
        .wdata   (retire.wdata)
    );

    exec_unit i_exec_unit (
        .clk         (clk),
        .reset       (reset),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_op      (alu_op),
        .alu_result  (alu_result),
        .retire_valid(retire_valid),
        .retire      (retire)
    );

    alu i_alu (
        .op    (alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .result(alu_result)
    );

endmodule
